// ==== hdl/cache_cfg.svh ====
`ifndef CACHE_CFG_SVH
`define CACHE_CFG_SVH

// address split into tag | index | byte offset in line
`define CACHE_TAG_W      20
`define CACHE_INDEX_W    8
`define CACHE_OFFSET_W   4

// geometry
`define CACHE_SETS       256
`define CACHE_BANKS      4
`define CACHE_WORD_W     32
`define CACHE_LINE_W     128

`define CACHE_LFSR_SEED  1   // any nonzero value works

`endif

// ==== hdl/cache_pkg.sv ====
`include "cache_cfg.svh"

package cache_pkg;

    // one-hot main FSM state
    typedef enum logic [4:0] {
        ST_IDLE    = 5'b00001,
        ST_LOOKUP  = 5'b00010,
        ST_MISS    = 5'b00100,
        ST_REPLACE = 5'b01000,
        ST_REFILL  = 5'b10000
    } cache_state_t;

    // request address as a raw word or as its fields
    typedef union packed {
        logic [31:0] word;
        struct packed {
            logic [`CACHE_TAG_W-1:0]   tag;
            logic [`CACHE_INDEX_W-1:0] index;
            logic [1:0]                bank;      // word within line
            logic [1:0]                byte_sel;
        } f;
    } cache_addr_u;

endpackage

// ==== hdl/req_buffer.sv ====
`include "cache_cfg.svh"

module req_buffer (
    input  logic                        clk,
    input  logic                        resetn,
    input  logic                        valid,
    input  logic                        op,
    input  logic [31:0]                 addr,
    input  logic [`CACHE_WORD_W/8-1:0]  wstrb,
    input  logic [`CACHE_WORD_W-1:0]    wdata,
    input  logic                        accept,
    input  cache_pkg::cache_state_t     state,
    output logic                        req_op,
    output cache_pkg::cache_addr_u      req_addr,
    output logic [`CACHE_WORD_W/8-1:0]  req_wstrb,
    output logic [`CACHE_WORD_W-1:0]    req_wdata,
    output logic [`CACHE_INDEX_W-1:0]   index
);
    import cache_pkg::*;

    cache_addr_u in_addr;

    assign in_addr.word = addr;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            req_op    <= 1'b0;
            req_addr  <= '0;
            req_wstrb <= '0;
            req_wdata <= '0;
        end else if (accept) begin
            req_op    <= op;
            req_addr  <= in_addr;
            req_wstrb <= wstrb;
            req_wdata <= wdata;
        end
    end

    // arrays read one cycle late, so idle looks at the incoming index
    assign index = (state == ST_IDLE) ? in_addr.f.index : req_addr.f.index;

endmodule

// ==== hdl/cache_way.sv ====
`include "cache_cfg.svh"

module cache_way (
    input  logic                                           clk,
    input  logic                                           resetn,
    input  logic [`CACHE_INDEX_W-1:0]                      index,
    input  logic [`CACHE_BANKS-1:0][`CACHE_WORD_W/8-1:0]   bank_we,
    input  logic [`CACHE_WORD_W-1:0]                       wdata,
    input  logic                                           tagv_we,
    input  logic [`CACHE_TAG_W-1:0]                        new_tag,
    input  logic                                           dirty_we,
    input  logic                                           dirty_val,
    output logic [`CACHE_BANKS-1:0][`CACHE_WORD_W-1:0]     bank_rdata,
    output logic [`CACHE_TAG_W-1:0]                        tag,
    output logic                                           valid,
    output logic                                           dirty
);
    logic [`CACHE_WORD_W-1:0] bank_mem [`CACHE_BANKS][`CACHE_SETS];
    logic [`CACHE_TAG_W-1:0]  tag_mem [`CACHE_SETS];
    logic [`CACHE_SETS-1:0]   valid_bits;
    logic [`CACHE_SETS-1:0]   dirty_bits;

    // byte-writable data banks with registered read
    always_ff @(posedge clk) begin
        for (int b = 0; b < `CACHE_BANKS; b++) begin
            for (int k = 0; k < `CACHE_WORD_W/8; k++) begin
                if (bank_we[b][k])
                    bank_mem[b][index][k*8 +: 8] <= wdata[k*8 +: 8];
            end
            bank_rdata[b] <= bank_mem[b][index];
        end
    end

    always_ff @(posedge clk) begin
        if (tagv_we)
            tag_mem[index] <= new_tag;
        tag <= tag_mem[index];
    end

    // valid bits with a registered read
    always_ff @(posedge clk) begin
        if (!resetn) begin
            valid_bits <= '0;
            valid      <= 1'b0;
        end else begin
            if (tagv_we)
                valid_bits[index] <= 1'b1;
            valid <= valid_bits[index];
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn)
            dirty_bits <= '0;
        else if (dirty_we)
            dirty_bits[index] <= dirty_val;
    end

    assign dirty = dirty_bits[index];   // no read latency

    // installing a line always sets or clears its dirty bit too
    a_tagv_dirty: assert property (@(posedge clk) disable iff (!resetn)
        tagv_we |-> dirty_we);

endmodule

// ==== hdl/cache_ctrl.sv ====
`include "cache_cfg.svh"

module cache_ctrl (
    input  logic                                                clk,
    input  logic                                                resetn,
    input  logic                                                valid,
    input  logic                                                req_op,
    input  cache_pkg::cache_addr_u                              req_addr,
    input  logic [`CACHE_WORD_W/8-1:0]                          req_wstrb,
    input  logic [`CACHE_WORD_W-1:0]                            req_wdata,
    input  logic [1:0][`CACHE_TAG_W-1:0]                        way_tag,
    input  logic [1:0]                                          way_valid,
    input  logic [1:0][`CACHE_BANKS-1:0][`CACHE_WORD_W-1:0]     way_bank,
    input  logic                                                ret_valid,
    input  logic                                                ret_last,
    input  logic [`CACHE_WORD_W-1:0]                            ret_data,
    input  logic                                                rd_rdy,
    input  logic                                                wr_rdy,
    input  logic [1:0]                                          beat,
    input  logic [`CACHE_WORD_W-1:0]                            miss_word,
    output cache_pkg::cache_state_t                             state,
    output logic                                                accept,
    output logic                                                addr_ok,
    output logic                                                data_ok,
    output logic [`CACHE_WORD_W-1:0]                            rdata,
    output logic [1:0][`CACHE_BANKS-1:0][`CACHE_WORD_W/8-1:0]   bank_we,
    output logic [1:0]                                          tagv_we,
    output logic [1:0]                                          dirty_we,
    output logic                                                dirty_val,
    output logic [`CACHE_WORD_W-1:0]                            wword,
    output logic                                                victim
);
    import cache_pkg::*;

    cache_state_t              next_state;
    logic [1:0]                hit;
    logic                      cache_hit;
    logic                      last_beat;
    logic [7:0]                lfsr;
    logic [`CACHE_WORD_W-1:0]  strb_mask;

    assign hit[0]    = way_valid[0] && (way_tag[0] == req_addr.f.tag);
    assign hit[1]    = way_valid[1] && (way_tag[1] == req_addr.f.tag);
    assign cache_hit = |hit;
    assign last_beat = (state == ST_REFILL) && ret_valid && ret_last;

    always_ff @(posedge clk) begin
        if (!resetn)
            state <= ST_IDLE;
        else
            state <= next_state;
    end

    always_comb begin
        next_state = state;
        case (state)
            ST_IDLE:
                if (valid)
                    next_state = ST_LOOKUP;
            ST_LOOKUP:
                next_state = cache_hit ? ST_IDLE : ST_MISS;
            ST_MISS:
                if (wr_rdy)        // write-back slot free
                    next_state = ST_REPLACE;
            ST_REPLACE:
                if (rd_rdy)
                    next_state = ST_REFILL;
            ST_REFILL:
                if (ret_valid && ret_last)
                    next_state = ST_IDLE;
            default:
                next_state = ST_IDLE;
        endcase
    end

    assign addr_ok = (state == ST_IDLE);
    assign accept  = addr_ok && valid;
    assign data_ok = ((state == ST_LOOKUP) && cache_hit) || last_beat;

    always_comb begin
        if (state == ST_LOOKUP)
            rdata = hit[1] ? way_bank[1][req_addr.f.bank] : way_bank[0][req_addr.f.bank];
        else if (req_addr.f.bank == 2'd3)
            rdata = ret_data;    // bank 3 arrives with the last beat and is not captured yet
        else
            rdata = miss_word;
    end

    always_comb begin
        for (int k = 0; k < `CACHE_WORD_W/8; k++)
            strb_mask[k*8 +: 8] = {8{req_wstrb[k]}};
    end

    // store bytes over the returned beat; on a hit only strobed bytes are written
    assign wword = ((state == ST_REFILL) && !(req_op && (beat == req_addr.f.bank)))
                 ? ret_data
                 : (strb_mask & req_wdata) | (~strb_mask & ret_data);

    always_comb begin
        bank_we  = '0;
        tagv_we  = '0;
        dirty_we = '0;
        for (int w = 0; w < 2; w++) begin
            if ((state == ST_LOOKUP) && req_op && hit[w]) begin
                bank_we[w][req_addr.f.bank] = req_wstrb;
                dirty_we[w]                 = 1'b1;
            end
            if ((state == ST_REFILL) && ret_valid && (victim == w[0])) begin
                bank_we[w][beat] = '1;
                tagv_we[w]       = ret_last;
                dirty_we[w]      = ret_last;
            end
        end
    end

    assign dirty_val = req_op;   // store leaves the line dirty

    // x^8 + x^6 + x^5 + x^4 + 1
    always_ff @(posedge clk) begin
        if (!resetn)
            lfsr <= 8'(`CACHE_LFSR_SEED);
        else if (last_beat)
            lfsr <= {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]};
    end

    assign victim = lfsr[0];

    a_one_way_hit: assert property (@(posedge clk) disable iff (!resetn)
        (state == ST_LOOKUP) |-> !(hit[0] && hit[1]));

    a_idle_no_data: assert property (@(posedge clk) disable iff (!resetn)
        (state == ST_IDLE) |-> !data_ok);

    a_state_onehot: assert property (@(posedge clk) disable iff (!resetn)
        $onehot(state));

endmodule

// ==== hdl/refill_unit.sv ====
`include "cache_cfg.svh"

module refill_unit (
    input  logic                                            clk,
    input  logic                                            resetn,
    input  cache_pkg::cache_state_t                         state,
    input  logic                                            ret_valid,
    input  logic                                            ret_last,
    input  logic [`CACHE_WORD_W-1:0]                        ret_data,
    input  cache_pkg::cache_addr_u                          req_addr,
    input  logic                                            victim,
    input  logic [1:0][`CACHE_BANKS-1:0][`CACHE_WORD_W-1:0] way_bank,
    input  logic [1:0][`CACHE_TAG_W-1:0]                    way_tag,
    input  logic [1:0]                                      way_valid,
    input  logic [1:0]                                      way_dirty,
    output logic [1:0]                                      beat,
    output logic [`CACHE_WORD_W-1:0]                        miss_word,
    output logic                                            rd_req,
    output logic [31:0]                                     rd_addr,
    output logic                                            wr_req,
    output logic [31:0]                                     wr_addr,
    output logic [`CACHE_LINE_W-1:0]                        wr_data
);
    import cache_pkg::*;

    logic was_miss;
    logic first_replace;

    always_ff @(posedge clk) begin
        if (!resetn)
            beat <= '0;
        else if ((state == ST_REFILL) && ret_valid)
            beat <= ret_last ? 2'd0 : beat + 2'd1;
    end

    // hold the requested word for the final data_ok
    always_ff @(posedge clk) begin
        if ((state == ST_REFILL) && ret_valid && (beat == req_addr.f.bank))
            miss_word <= ret_data;
    end

    always_ff @(posedge clk) begin
        if (!resetn)
            was_miss <= 1'b0;
        else
            was_miss <= (state == ST_MISS);
    end

    assign first_replace = was_miss && (state == ST_REPLACE);

    assign rd_req  = (state == ST_REPLACE);
    assign rd_addr = {req_addr.f.tag, req_addr.f.index, {`CACHE_OFFSET_W{1'b0}}};

    // victim line is still on the bank outputs, refill has not touched it
    assign wr_req  = first_replace && way_valid[victim] && way_dirty[victim];
    assign wr_addr = {way_tag[victim], req_addr.f.index, {`CACHE_OFFSET_W{1'b0}}};
    assign wr_data = way_bank[victim];

    a_last_on_fourth: assert property (@(posedge clk) disable iff (!resetn)
        ((state == ST_REFILL) && ret_valid && ret_last) |-> (beat == 2'(`CACHE_BANKS-1)));

endmodule

// ==== hdl/cache_top.sv ====
`include "cache_cfg.svh"

module cache_top (
    input  logic                         clk,
    input  logic                         resetn,
    input  logic                         valid,
    input  logic                         op,
    input  logic [31:0]                  addr,
    input  logic [`CACHE_WORD_W/8-1:0]   wstrb,
    input  logic [`CACHE_WORD_W-1:0]     wdata,
    output logic                         addr_ok,
    output logic                         data_ok,
    output logic [`CACHE_WORD_W-1:0]     rdata,
    output logic                         rd_req,
    output logic [31:0]                  rd_addr,
    input  logic                         rd_rdy,
    input  logic                         ret_valid,
    input  logic                         ret_last,
    input  logic [`CACHE_WORD_W-1:0]     ret_data,
    output logic                         wr_req,
    output logic [31:0]                  wr_addr,
    output logic [`CACHE_LINE_W-1:0]     wr_data,
    input  logic                         wr_rdy
);
    import cache_pkg::*;

    cache_state_t                                          state;
    cache_addr_u                                           req_addr;
    logic                                                  accept;
    logic                                                  req_op;
    logic [`CACHE_WORD_W/8-1:0]                            req_wstrb;
    logic [`CACHE_WORD_W-1:0]                              req_wdata;
    logic [`CACHE_INDEX_W-1:0]                             index;
    logic [1:0][`CACHE_BANKS-1:0][`CACHE_WORD_W-1:0]       way_bank;
    logic [1:0][`CACHE_TAG_W-1:0]                          way_tag;
    logic [1:0]                                            way_valid;
    logic [1:0]                                            way_dirty;
    logic [1:0][`CACHE_BANKS-1:0][`CACHE_WORD_W/8-1:0]     bank_we;
    logic [1:0]                                            tagv_we;
    logic [1:0]                                            dirty_we;
    logic                                                  dirty_val;
    logic [`CACHE_WORD_W-1:0]                              wword;
    logic                                                  victim;
    logic [1:0]                                            beat;
    logic [`CACHE_WORD_W-1:0]                              miss_word;

    req_buffer u_req (
        .clk(clk), .resetn(resetn), .valid(valid), .op(op), .addr(addr),
        .wstrb(wstrb), .wdata(wdata), .accept(accept), .state(state),
        .req_op(req_op), .req_addr(req_addr), .req_wstrb(req_wstrb),
        .req_wdata(req_wdata), .index(index)
    );

    cache_way way0 (
        .clk(clk), .resetn(resetn), .index(index), .bank_we(bank_we[0]),
        .wdata(wword), .tagv_we(tagv_we[0]), .new_tag(req_addr.f.tag),
        .dirty_we(dirty_we[0]), .dirty_val(dirty_val), .bank_rdata(way_bank[0]),
        .tag(way_tag[0]), .valid(way_valid[0]), .dirty(way_dirty[0])
    );

    cache_way way1 (
        .clk(clk), .resetn(resetn), .index(index), .bank_we(bank_we[1]),
        .wdata(wword), .tagv_we(tagv_we[1]), .new_tag(req_addr.f.tag),
        .dirty_we(dirty_we[1]), .dirty_val(dirty_val), .bank_rdata(way_bank[1]),
        .tag(way_tag[1]), .valid(way_valid[1]), .dirty(way_dirty[1])
    );

    cache_ctrl u_ctrl (
        .clk(clk), .resetn(resetn), .valid(valid), .req_op(req_op),
        .req_addr(req_addr), .req_wstrb(req_wstrb), .req_wdata(req_wdata),
        .way_tag(way_tag), .way_valid(way_valid), .way_bank(way_bank),
        .ret_valid(ret_valid), .ret_last(ret_last), .ret_data(ret_data),
        .rd_rdy(rd_rdy), .wr_rdy(wr_rdy), .beat(beat), .miss_word(miss_word),
        .state(state), .accept(accept), .addr_ok(addr_ok), .data_ok(data_ok),
        .rdata(rdata), .bank_we(bank_we), .tagv_we(tagv_we), .dirty_we(dirty_we),
        .dirty_val(dirty_val), .wword(wword), .victim(victim)
    );

    refill_unit u_refill (
        .clk(clk), .resetn(resetn), .state(state), .ret_valid(ret_valid),
        .ret_last(ret_last), .ret_data(ret_data), .req_addr(req_addr),
        .victim(victim), .way_bank(way_bank), .way_tag(way_tag),
        .way_valid(way_valid), .way_dirty(way_dirty), .beat(beat),
        .miss_word(miss_word), .rd_req(rd_req), .rd_addr(rd_addr),
        .wr_req(wr_req), .wr_addr(wr_addr), .wr_data(wr_data)
    );

endmodule

// ==== sim/tb_cache.sv ====
module tb_cache;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int MAX_PAT = 64;
    localparam int FIELDS  = 6;     // op addr wstrb wdata expect kind

    logic         clk;
    logic         resetn    = 1'b0;
    logic         valid     = 1'b0;
    logic         op        = 1'b0;
    logic [31:0]  addr      = '0;
    logic [3:0]   wstrb     = '0;
    logic [31:0]  wdata     = '0;
    logic         rd_rdy    = 1'b0;
    logic         ret_valid = 1'b0;
    logic         ret_last  = 1'b0;
    logic [31:0]  ret_data  = '0;
    logic         wr_rdy    = 1'b0;
    logic         addr_ok;
    logic         data_ok;
    logic [31:0]  rdata;
    logic         rd_req;
    logic [31:0]  rd_addr;
    logic         wr_req;
    logic [31:0]  wr_addr;
    logic [127:0] wr_data;

    logic [31:0]  pat_mem [MAX_PAT*FIELDS];
    logic [127:0] mem [logic [27:0]];     // written-back lines by line address
    int           npat     = 0;
    bit           loaded   = 1'b0;
    int           errors   = 0;
    int           rd_count = 0;           // line reads taken by the memory
    logic [31:0]  rng      = 32'h7055_1e88;
    bit           reading  = 1'b0;
    logic [27:0]  rline;
    logic [1:0]   rbeat;

    cache_top uut (
        .clk(clk), .resetn(resetn), .valid(valid), .op(op), .addr(addr),
        .wstrb(wstrb), .wdata(wdata), .addr_ok(addr_ok), .data_ok(data_ok),
        .rdata(rdata), .rd_req(rd_req), .rd_addr(rd_addr), .rd_rdy(rd_rdy),
        .ret_valid(ret_valid), .ret_last(ret_last), .ret_data(ret_data),
        .wr_req(wr_req), .wr_addr(wr_addr), .wr_data(wr_data), .wr_rdy(wr_rdy)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // untouched memory holds its own address xor a marker
    function automatic logic [31:0] line_word(input logic [27:0] line, input logic [1:0] b);
        if (mem.exists(line))
            return mem[line][b*32 +: 32];
        return {line, b, 2'b00} ^ 32'hc0de_0000;
    endfunction

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp) begin
            $display("MISMATCH at %0d ns: %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    // memory model with random stalls on every handshake
    always @(posedge clk) begin
        if (!resetn) begin
            rd_rdy    <= 1'b0;
            wr_rdy    <= 1'b0;
            ret_valid <= 1'b0;
            ret_last  <= 1'b0;
            reading   = 1'b0;
            rbeat     = 2'd0;
        end else begin
            rng = xorshift32(rng);
            rd_rdy <= rng[0] | rng[1];
            wr_rdy <= rng[2] | rng[3];
            if (wr_req) begin                   // dirty victim
                // the victim always sits in the requested set
                compare_value("wr_addr set", {20'h0, wr_addr[11:0]},
                              {20'h0, addr[11:4], 4'h0});
                mem[wr_addr[31:4]] = wr_data;
            end
            if (ret_valid) begin                // beat taken at this edge
                if (ret_last)
                    reading = 1'b0;
                rbeat = rbeat + 2'd1;
            end
            if (rd_req && rd_rdy && !reading) begin
                compare_value("rd_addr", rd_addr, {addr[31:4], 4'h0});
                reading = 1'b1;
                rline   = rd_addr[31:4];
                rbeat   = 2'd0;
                rd_count <= rd_count + 1;
            end
            if (reading && (rng[4] | rng[5])) begin
                ret_valid <= 1'b1;
                ret_data  <= line_word(rline, rbeat);
                ret_last  <= (rbeat == 2'd3);
            end else begin
                ret_valid <= 1'b0;
                ret_last  <= 1'b0;
            end
        end
    end

    task automatic run_pattern(input int i);
        logic [31:0] p_op;
        logic [31:0] p_addr;
        logic [31:0] p_kind;
        logic [31:0] p_exp;
        int          reads0;
        int          lat;
        int          err0;
        p_op   = pat_mem[i*FIELDS];
        p_addr = pat_mem[i*FIELDS+1];
        p_exp  = pat_mem[i*FIELDS+4];
        p_kind = pat_mem[i*FIELDS+5];
        err0   = errors;
        valid <= 1'b1;
        op    <= p_op[0];
        addr  <= p_addr;
        wstrb <= pat_mem[i*FIELDS+2][3:0];
        wdata <= pat_mem[i*FIELDS+3];
        @(posedge clk);
        while (!addr_ok)
            @(posedge clk);
        valid  <= 1'b0;   // accepted on this edge
        reads0 = rd_count;
        lat    = 0;
        do begin
            @(posedge clk);
            lat++;
        end while (!data_ok);
        if (!p_op[0])
            compare_value("rdata", rdata, p_exp);
        case (p_kind)
            0: begin
                compare_value("rd_req count", rd_count - reads0, 0);
                compare_value("hit latency", lat, 1);
            end
            1: compare_value("rd_req count", rd_count - reads0, 1);
            default:
                if (rd_count - reads0 > 1) begin
                    $display("pattern %0d issued more than one line read", i);
                    errors++;
                end
        endcase
        $display("pattern %0d: %s %h %s", i, p_op[0] ? "store" : "load", p_addr,
                 (errors == err0) ? "ok" : "failed");
    endtask

    initial begin : main
        for (int k = 0; k < MAX_PAT*FIELDS; k++)
            pat_mem[k] = '1;
        $readmemh("sim/cache_patterns.txt", pat_mem);
        while (npat < MAX_PAT && pat_mem[npat*FIELDS] != 32'hffff_ffff)
            npat++;
        loaded = 1'b1;
        if (npat == 0) begin
            $display("no patterns could be read from the pattern file");
            errors++;
        end
        repeat (4) @(posedge clk);
        resetn <= 1'b1;
        @(posedge clk);
        compare_value("addr_ok", addr_ok, 1);
        compare_value("data_ok", data_ok, 0);
        compare_value("rd_req", rd_req, 0);
        compare_value("wr_req", wr_req, 0);
        $display("reset state: %s", (errors == 0) ? "ok" : "failed");
        for (int i = 0; i < npat; i++)
            run_pattern(i);
        $display("done: %0d patterns, %0d errors", npat, errors);
        if (errors == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

    // each pattern gets a generous budget, stalls included
    initial begin : watchdog
        wait (loaded);
        repeat (npat * 200 + 20) @(posedge clk);
        $display("timeout: the run did not finish within %0d cycles", npat * 200 + 20);
        $display("Result: FAILED");
        $finish;
    end

endmodule

// ==== cache.f ====
+incdir+hdl
hdl/cache_pkg.sv
hdl/req_buffer.sv
hdl/cache_way.sv
hdl/cache_ctrl.sv
hdl/refill_unit.sv
hdl/cache_top.sv
sim/tb_cache.sv

// ==== Makefile ====
TOP = tb_cache

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): cache.f hdl/cache_cfg.svh hdl/*.sv sim/tb_cache.sv sim/cache_patterns.txt
	verilator --binary --timing --assert --timescale 1ns/100ps \
		-f cache.f --top-module $(TOP)

run: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -q "Result: PASSED"

lint:
	verilator --lint-only --timing --timescale 1ns/100ps \
		-f cache.f --top-module cache_top

clean:
	rm -rf obj_dir

// ==== sim/cache_patterns.txt ====
// op addr wstrb wdata expect kind   (op 1 = store, expect only used for loads)
// kind 0 = hit, 1 = miss, 2 = either
0 00001000 0 00000000 c0de1000 1
0 0000100c 0 00000000 c0de100c 0
1 00001004 3 aabbccdd 00000000 0
0 00001004 0 00000000 c0deccdd 0
1 00005018 c 11223344 00000000 1
0 00005018 0 00000000 11225018 0
0 00005010 0 00000000 c0de5010 0
0 0000603c 0 00000000 c0de603c 1
1 00006030 f deadbeef 00000000 0
0 00006030 0 00000000 deadbeef 0
0 00007000 0 00000000 c0de7000 1
1 00007008 1 00000055 00000000 0
0 00008004 0 00000000 c0de8004 1
0 00009000 0 00000000 c0de9000 1
0 00001004 0 00000000 c0deccdd 2
0 00007008 0 00000000 c0de7055 2
0 0000a00c 0 00000000 c0dea00c 1
0 0000b000 0 00000000 c0deb000 1
0 00007008 0 00000000 c0de7055 2
0 0000100c 0 00000000 c0de100c 2
0 00006030 0 00000000 deadbeef 0
1 0001203c 6 00abcd00 00000000 1
0 0001203c 0 00000000 c0abcd3c 0
0 00006030 0 00000000 deadbeef 2
